// File: vlog.f
hw/vis_pkg.sv
hw/vis_bank_queue.sv
hw/vis_fetch.sv
hw/vis_store.sv
hw/vis_top.sv
testbench/tb_vis_top.sv
+incdir+testbench

// File: Makefile
# Verilator build for the visibilities prefetch testbench

VERILATOR ?= verilator
TOP       ?= tb_vis_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(wildcard hw/*.sv testbench/*.sv testbench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, the pass line decides the exit status
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_vis_models.svh
`ifndef TB_VIS_MODELS_SVH
`define TB_VIS_MODELS_SVH

   // --------------------------------------------------
   // random numbers and correlator contents
   // --------------------------------------------------
   logic [31:0] rand_state;   // wait state generator
   int          fetch_bank;   // bank the slave is serving
   int          wait_left;    // -1 between bus cycles

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rand_state = xorshift32(rand_state);
      return rand_state;
   endfunction

   // word at address a after swap n
   function automatic logic [31:0] bank_word(input int n, input logic [ABITS-1:0] a);
      logic [31:0] mix;
      mix = xorshift32(SEED ^ (32'(n) * 32'h9e37_79b9));   // spread the bank number
      return xorshift32(mix ^ 32'(a));
   endfunction

   // xor over every block and word of bank n
   function automatic logic [31:0] bank_checksum(input int n);
      logic [31:0] sum;
      sum = '0;
      for (int b = 0; b < COUNT; b++) begin
         for (int w = 0; w < BSIZE; w++) begin
            sum = sum ^ bank_word(n, {b[CBITS-1:0], w[BBITS-1:0]});
         end
      end
      return sum;
   endfunction

   // --------------------------------------------------
   // correlator memory, wishbone classic slave
   // --------------------------------------------------
   initial begin
      rand_state = SEED;
      fetch_bank = 0;
      wait_left  = -1;
      ack_i      = 1'b0;
      dat_i      = '0;
      forever begin
         @(posedge clk_i);
         #1;
         if (rst_i || ack_i) begin
            ack_i     = 1'b0;   // master closes the cycle on the ack edge
            dat_i     = '0;
            wait_left = -1;
         end else if (stb_o) begin
            if (wait_left < 0) wait_left = int'(next_random() % 32'd4);   // 0 to 3 waits
            if (wait_left == 0) begin
               ack_i = 1'b1;
               dat_i = bank_word(fetch_bank, adr_o);
               if (adr_o == LAST_ADR) fetch_bank++;   // bank fully read
            end else begin
               wait_left--;
            end
         end
      end
   end

   // --------------------------------------------------
   // local sram
   // --------------------------------------------------
   logic [WIDTH-1:0] sram [0:2**ABITS-1];

   initial begin
      for (int i = 0; i < 2**ABITS; i++) begin
         sram[i] = 32'h5a5a_0000 ^ 32'(i);   // unique per address, shows missed writes
      end
      forever begin
         @(posedge clk_i);
         if (sram_ce_o && sram_we_o) begin
            for (int k = 0; k < WIDTH/8; k++) begin
               if (sram_be_o[k]) sram[sram_ad_o][8*k +: 8] = sram_di_o[8*k +: 8];
            end
         end
      end
   end

`endif

// File: testbench/tb_vis_top.sv
`timescale 1ns/1ps

module tb_vis_top;

   // --------------------------------------------------
   // geometry and run length
   // --------------------------------------------------
   localparam int COUNT = vis_pkg::VIS_COUNT;
   localparam int CBITS = vis_pkg::VIS_CBITS;
   localparam int BSIZE = vis_pkg::VIS_BSIZE;
   localparam int BBITS = vis_pkg::VIS_BBITS;
   localparam int WIDTH = vis_pkg::VIS_WIDTH;
   localparam int XBITS = vis_pkg::VIS_XBITS;
   localparam int ABITS = CBITS + BBITS;

   localparam logic [31:0]      SEED            = 32'h79d4_c46f;
   localparam int               BANKS_TOTAL     = 8;                   // 1 + 3 + 4
   localparam int               BANK_CYCLES     = COUNT * BSIZE * 6;   // beat is 5 at worst
   localparam int               WATCHDOG_CYCLES = BANKS_TOTAL * BANK_CYCLES + 5000;
   localparam logic [ABITS-1:0] LAST_ADR        = {CBITS'(COUNT - 1), BBITS'(BSIZE - 1)};

   logic               clk_i;
   logic               rst_i;
   logic               switch_i;
   logic               streamed_i;
   logic               cyc_o;
   logic               stb_o;
   logic               we_o;
   logic [ABITS-1:0]   adr_o;
   logic [WIDTH/8-1:0] sel_o;
   logic               ack_i;
   logic [WIDTH-1:0]   dat_i;
   logic               sram_ce_o;
   logic               sram_we_o;
   logic [ABITS-1:0]   sram_ad_o;
   logic [WIDTH/8-1:0] sram_be_o;
   logic [WIDTH-1:0]   sram_di_o;
   logic               newblock_o;
   logic [WIDTH-1:0]   checksum_o;
   logic               overflow_o;

   string test_name;
   int    data_errors;
   int    bus_errors;
   int    banks_seen;   // newblock pulses checked so far
   logic  held_q;       // bank sits in sram until streamed

   vis_top #(
      .COUNT (COUNT),
      .CBITS (CBITS),
      .BSIZE (BSIZE),
      .BBITS (BBITS),
      .WIDTH (WIDTH),
      .XBITS (XBITS)
   ) vis_top_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .switch_i   (switch_i),
      .streamed_i (streamed_i),
      .cyc_o      (cyc_o),
      .stb_o      (stb_o),
      .we_o       (we_o),
      .adr_o      (adr_o),
      .sel_o      (sel_o),
      .ack_i      (ack_i),
      .dat_i      (dat_i),
      .sram_ce_o  (sram_ce_o),
      .sram_we_o  (sram_we_o),
      .sram_ad_o  (sram_ad_o),
      .sram_be_o  (sram_be_o),
      .sram_di_o  (sram_di_o),
      .newblock_o (newblock_o),
      .checksum_o (checksum_o),
      .overflow_o (overflow_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;   // 8 ns period
   end

   `include "tb_vis_models.svh"

   always @(posedge clk_i) begin
      if (rst_i) held_q <= 1'b0;
      else if (newblock_o) held_q <= 1'b1;
      else if (streamed_i) held_q <= 1'b0;   // readout released the buffer
   end

   // --------------------------------------------------
   // protocol and reset assertions
   // --------------------------------------------------
   reset_idle: assert property (@(posedge clk_i) rst_i |=> (!cyc_o && !stb_o && !sram_we_o
                                && !newblock_o && !overflow_o && checksum_o == '0))
      else begin
         bus_errors++;
         $display("%s: outputs not idle after a reset cycle", test_name);
      end

   wb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
                             stb_o && !ack_i |=> stb_o && cyc_o && $stable(adr_o))
      else begin
         bus_errors++;
         $display("%s: request moved during a wait state, fetch in %s", test_name,
                  vis_top_i.vis_fetch_i.state_q.name());
      end

   wb_gap: assert property (@(posedge clk_i) disable iff (rst_i) stb_o && ack_i |=> !stb_o)
      else begin
         bus_errors++;
         $display("%s: stb_o did not drop after an ack", test_name);
      end

   wb_static: assert property (@(posedge clk_i) disable iff (rst_i)
                               !we_o && sel_o == '1 && cyc_o == stb_o)
      else begin
         bus_errors++;
         $display("%s: we_o, sel_o or cyc_o against stb_o is wrong", test_name);
      end

   bus_quiet: assert property (@(posedge clk_i) disable iff (rst_i) held_q |-> !cyc_o)
      else begin
         bus_errors++;
         $display("%s: bus cycle started before the buffer was streamed, buffer %s",
                  test_name, vis_top_i.vis_bank_queue_i.state_q.name());
      end

   overflow_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
                                     overflow_o |=> overflow_o)
      else begin
         bus_errors++;
         $display("%s: overflow_o cleared without reset", test_name);
      end

   // --------------------------------------------------
   // bank contents, checked mid cycle on newblock
   // --------------------------------------------------
   always @(negedge clk_i) begin
      logic [ABITS-1:0] a;
      logic [31:0]      expected;
      if (!rst_i && newblock_o) begin
         for (int b = 0; b < COUNT; b++) begin
            for (int w = 0; w < BSIZE; w++) begin
               a        = {b[CBITS-1:0], w[BBITS-1:0]};
               expected = bank_word(banks_seen, a);
               assert (sram[a] === expected) else begin
                  data_errors++;
                  $display("Mismatch %s: bank %0d sram[%0d] expected %h actual %h",
                           test_name, banks_seen, a, expected, sram[a]);
               end
            end
         end
         expected = bank_checksum(banks_seen);
         assert (checksum_o === expected) else begin
            data_errors++;
            $display("Mismatch %s: bank %0d checksum expected %h actual %h",
                     test_name, banks_seen, expected, checksum_o);
         end
         banks_seen++;
      end
   end

   // --------------------------------------------------
   // stimulus helpers, all start and end 1 ns past an edge
   // --------------------------------------------------
   task automatic step(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic pulse_switch(input int n);
      switch_i = 1'b1;   // n swaps back to back
      step(n);
      switch_i = 1'b0;
   endtask

   task automatic pulse_streamed();
      streamed_i = 1'b1;
      step(1);
      streamed_i = 1'b0;
   endtask

   task automatic wait_newblock();
      int target;
      int cycles;
      target = banks_seen + 1;
      cycles = 0;
      while (banks_seen < target && cycles < BANK_CYCLES) begin
         step(1);
         cycles++;
      end
      if (banks_seen < target) begin
         data_errors++;
         $display("%s: no newblock_o within %0d cycles", test_name, BANK_CYCLES);
      end
   endtask

   // a queued swap would open a bus cycle a few cycles after streaming
   task automatic expect_bus_idle(input int n);
      repeat (n) begin
         step(1);
         assert (!cyc_o) else begin
            bus_errors++;
            $display("%s: bus cycle started with no swap pending", test_name);
         end
      end
   endtask

   task automatic compare_int(input string what, input int expected, input int actual);
      assert (actual == expected) else begin
         data_errors++;
         $display("Mismatch %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      rst_i      = 1'b1;
      switch_i   = 1'b0;
      streamed_i = 1'b0;
      test_name  = "reset";
      repeat (16) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      step(4);

      test_name = "single_bank";
      pulse_switch(1);
      wait_newblock();
      step(10);
      pulse_streamed();
      step(10);

      test_name = "ordering";
      pulse_switch(3);
      repeat (3) begin
         wait_newblock();
         step(10);        // readout still busy, bus held off
         pulse_streamed();
      end
      expect_bus_idle(50);   // nothing left queued
      compare_int("newblock count", 4, banks_seen);
      compare_int("overflow_o", 0, int'(overflow_o));

      test_name = "overflow";
      pulse_switch(1);
      wait_newblock();    // buffer full, nothing pending
      pulse_switch(4);    // fourth swap finds three pending
      step(4);
      compare_int("overflow_o", 1, int'(overflow_o));
      repeat (3) begin
         pulse_streamed();
         wait_newblock();
      end
      pulse_streamed();
      expect_bus_idle(200);   // dropped swap must stay dropped
      compare_int("newblock count", BANKS_TOTAL, banks_seen);

      $display("errors: data %0d, bus %0d, total %0d", data_errors, bus_errors,
               data_errors + bus_errors);
      if (data_errors + bus_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
      $display("Test failures found");
      $finish;
   end

endmodule

// File: hw/vis_top.sv
`timescale 1ns/1ps

module vis_top #(
   parameter int COUNT = vis_pkg::VIS_COUNT,
   parameter int CBITS = vis_pkg::VIS_CBITS,
   parameter int BSIZE = vis_pkg::VIS_BSIZE,
   parameter int BBITS = vis_pkg::VIS_BBITS,
   parameter int WIDTH = vis_pkg::VIS_WIDTH,
   parameter int XBITS = vis_pkg::VIS_XBITS,
   localparam int ABITS = CBITS + BBITS   // block and word fields
) (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               switch_i,     // bank swap pulse
   input  logic               streamed_i,   // readout finished

   // wishbone classic master toward correlator memory
   output logic               cyc_o,
   output logic               stb_o,
   output logic               we_o,
   output logic [ABITS-1:0]   adr_o,
   output logic [WIDTH/8-1:0] sel_o,
   input  logic               ack_i,
   input  logic [WIDTH-1:0]   dat_i,

   // local sram
   output logic               sram_ce_o,
   output logic               sram_we_o,
   output logic [ABITS-1:0]   sram_ad_o,
   output logic [WIDTH/8-1:0] sram_be_o,
   output logic [WIDTH-1:0]   sram_di_o,

   // status
   output logic               newblock_o,
   output logic [WIDTH-1:0]   checksum_o,
   output logic               overflow_o
);

   logic             start_w;
   logic             done_w;
   logic             beat_w;
   logic [ABITS-1:0] beat_adr_w;
   logic [WIDTH-1:0] beat_dat_w;
   logic             last_w;

   // --------------------------------------------------
   // queue -> fetch -> store
   // --------------------------------------------------
   vis_bank_queue #(
      .XBITS (XBITS)
   ) vis_bank_queue_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .switch_i   (switch_i),
      .streamed_i (streamed_i),
      .done_i     (done_w),
      .start_o    (start_w),
      .overflow_o (overflow_o)
   );

   vis_fetch #(
      .COUNT (COUNT),
      .CBITS (CBITS),
      .BSIZE (BSIZE),
      .BBITS (BBITS),
      .WIDTH (WIDTH),
      .ABITS (ABITS)
   ) vis_fetch_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .start_i    (start_w),
      .cyc_o      (cyc_o),
      .stb_o      (stb_o),
      .we_o       (we_o),
      .adr_o      (adr_o),
      .sel_o      (sel_o),
      .ack_i      (ack_i),
      .dat_i      (dat_i),
      .beat_o     (beat_w),
      .beat_adr_o (beat_adr_w),
      .beat_dat_o (beat_dat_w),
      .last_o     (last_w),
      .done_o     (done_w)
   );

   vis_store #(
      .WIDTH (WIDTH),
      .ABITS (ABITS)
   ) vis_store_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .beat_i     (beat_w),
      .beat_adr_i (beat_adr_w),
      .beat_dat_i (beat_dat_w),
      .last_i     (last_w),
      .sram_ce_o  (sram_ce_o),
      .sram_we_o  (sram_we_o),
      .sram_ad_o  (sram_ad_o),
      .sram_be_o  (sram_be_o),
      .sram_di_o  (sram_di_o),
      .newblock_o (newblock_o),
      .checksum_o (checksum_o)
   );

endmodule

// File: hw/vis_store.sv
`timescale 1ns/1ps

module vis_store #(
   parameter int WIDTH = 32,
   parameter int ABITS = 10
) (
   input  logic               clk_i,
   input  logic               rst_i,

   // beats from the fetch stage
   input  logic               beat_i,
   input  logic [ABITS-1:0]   beat_adr_i,
   input  logic [WIDTH-1:0]   beat_dat_i,
   input  logic               last_i,

   // local sram write port
   output logic               sram_ce_o,
   output logic               sram_we_o,
   output logic [ABITS-1:0]   sram_ad_o,
   output logic [WIDTH/8-1:0] sram_be_o,
   output logic [WIDTH-1:0]   sram_di_o,

   // status
   output logic               newblock_o,   // bank is in sram
   output logic [WIDTH-1:0]   checksum_o    // xor over the whole bank
);

   logic restart_q;   // next beat opens a new bank
   logic last_q;      // last write going out this cycle

   assign sram_be_o = {(WIDTH/8){1'b1}};   // full word writes only

   // --------------------------------------------------
   // sram write, one cycle behind the beat
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sram_ce_o <= 1'b0;
         sram_we_o <= 1'b0;
      end else begin
         sram_ce_o <= beat_i;
         sram_we_o <= beat_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (beat_i) begin
         sram_ad_o <= beat_adr_i;   // same address as the correlator word
         sram_di_o <= beat_dat_i;
      end
   end

   // --------------------------------------------------
   // checksum and bank complete
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         checksum_o <= '0;
         restart_q  <= 1'b1;
      end else if (beat_i) begin
         // previous total held until the first word of the next bank
         checksum_o <= restart_q ? beat_dat_i : (checksum_o ^ beat_dat_i);
         restart_q  <= last_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         last_q     <= 1'b0;
         newblock_o <= 1'b0;
      end else begin
         last_q     <= beat_i && last_i;   // lines up with the final write
         newblock_o <= last_q;             // strobe the cycle after
      end
   end

endmodule

// File: hw/vis_fetch.sv
`timescale 1ns/1ps

module vis_fetch #(
   parameter int COUNT = 24,
   parameter int CBITS = 5,
   parameter int BSIZE = 24,
   parameter int BBITS = 5,
   parameter int WIDTH = 32,
   parameter int ABITS = 10
) (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               start_i,

   // wishbone classic master, reads only
   output logic               cyc_o,
   output logic               stb_o,
   output logic               we_o,
   output logic [ABITS-1:0]   adr_o,
   output logic [WIDTH/8-1:0] sel_o,
   input  logic               ack_i,
   input  logic [WIDTH-1:0]   dat_i,

   // beats toward the store stage
   output logic               beat_o,
   output logic [ABITS-1:0]   beat_adr_o,
   output logic [WIDTH-1:0]   beat_dat_o,
   output logic               last_o,
   output logic               done_o
);

   vis_pkg::fetch_state_e state_q;
   logic                  req_q;   // drives cyc and stb together
   logic [CBITS-1:0]      blk_q;   // block number
   logic [BBITS-1:0]      wrd_q;   // word within block
   logic                  wrd_end_w;
   logic                  blk_end_w;
   logic                  ack_w;

   assign wrd_end_w = (wrd_q == BBITS'(BSIZE - 1));
   assign blk_end_w = (blk_q == CBITS'(COUNT - 1));
   assign ack_w     = req_q && ack_i;   // ignore stray acks outside a cycle

   // --------------------------------------------------
   // bus side
   // --------------------------------------------------
   assign cyc_o = req_q;
   assign stb_o = req_q;
   assign we_o  = 1'b0;
   assign sel_o = {(WIDTH/8){1'b1}};   // whole words
   assign adr_o = {blk_q, wrd_q};      // block high, word low

   // each acked word goes straight on as a beat
   assign beat_o     = ack_w;
   assign beat_adr_o = adr_o;
   assign beat_dat_o = dat_i;
   assign last_o     = ack_w && wrd_end_w && blk_end_w;
   assign done_o     = last_o;

   // --------------------------------------------------
   // fetch FSM
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= vis_pkg::FETCH_IDLE;
         req_q   <= 1'b0;
         blk_q   <= '0;
         wrd_q   <= '0;
      end else begin
         case (state_q)
            vis_pkg::FETCH_IDLE: begin
               if (start_i) begin
                  blk_q   <= '0;   // start of bank
                  wrd_q   <= '0;
                  req_q   <= 1'b1;
                  state_q <= vis_pkg::FETCH_BUS;
               end
            end
            vis_pkg::FETCH_BUS: begin
               // hold request and address through wait states
               if (ack_w) begin
                  req_q   <= 1'b0;
                  state_q <= (wrd_end_w && blk_end_w) ? vis_pkg::FETCH_IDLE
                                                      : vis_pkg::FETCH_NEXT;
               end
            end
            vis_pkg::FETCH_NEXT: begin
               if (wrd_end_w) begin
                  wrd_q <= '0;
                  blk_q <= blk_q + 1'b1;   // roll into next block
               end else begin
                  wrd_q <= wrd_q + 1'b1;
               end
               req_q   <= 1'b1;            // new cycle after one idle gap
               state_q <= vis_pkg::FETCH_BUS;
            end
            default: begin
               req_q   <= 1'b0;
               state_q <= vis_pkg::FETCH_IDLE;
            end
         endcase
      end
   end

endmodule

// File: hw/vis_bank_queue.sv
`timescale 1ns/1ps

module vis_bank_queue #(
   parameter int XBITS = 2
) (
   input  logic clk_i,
   input  logic rst_i,
   input  logic switch_i,     // one pulse per bank swap
   input  logic streamed_i,   // readout has sent the buffer
   input  logic done_i,       // last word of the bank fetched
   output logic start_o,      // kicks off one prefetch
   output logic overflow_o    // sticky, a swap was lost
);

   logic [XBITS-1:0]    count_q;   // swaps waiting for the buffer
   vis_pkg::buf_state_e state_q;
   logic                full_w;
   logic                push_w;
   logic                pop_w;

   assign full_w = &count_q;                    // all ones is the ceiling
   assign push_w = switch_i && !full_w;         // swaps past the ceiling are dropped
   assign pop_w  = (state_q == vis_pkg::BUF_EMPTY) && (count_q != '0);

   // --------------------------------------------------
   // pending swap counter
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (push_w && !pop_w) begin
         count_q <= count_q + 1'b1;
      end else if (pop_w && !push_w) begin
         count_q <= count_q - 1'b1;
      end   // both or neither leaves it alone
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         overflow_o <= 1'b0;
      end else if (switch_i && full_w) begin
         overflow_o <= 1'b1;   // held until reset
      end
   end

   // --------------------------------------------------
   // buffer occupancy
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= vis_pkg::BUF_EMPTY;
         start_o <= 1'b0;
      end else begin
         start_o <= 1'b0;                       // single cycle pulse
         case (state_q)
            vis_pkg::BUF_EMPTY: begin
               if (pop_w) begin
                  start_o <= 1'b1;
                  state_q <= vis_pkg::BUF_FILLING;
               end
            end
            vis_pkg::BUF_FILLING: begin
               if (done_i) state_q <= vis_pkg::BUF_FULL;
            end
            vis_pkg::BUF_FULL: begin
               if (streamed_i) state_q <= vis_pkg::BUF_EMPTY;  // readout drained it
            end
            default: state_q <= vis_pkg::BUF_EMPTY;
         endcase
      end
   end

endmodule

// File: hw/vis_pkg.sv
package vis_pkg;

   // --------------------------------------------------
   // default prefetch geometry
   // --------------------------------------------------
   localparam int VIS_COUNT = 24;   // blocks per bank
   localparam int VIS_CBITS = 5;    // block counter width
   localparam int VIS_BSIZE = 24;   // words per block
   localparam int VIS_BBITS = 5;    // word counter width
   localparam int VIS_WIDTH = 32;   // correlator data width
   localparam int VIS_XBITS = 2;    // pending swaps, at most 3 queued

   // --------------------------------------------------
   // state encodings
   // --------------------------------------------------

   // wishbone read master
   typedef enum logic [1:0] {
      FETCH_IDLE = 2'd0,   // waiting for start
      FETCH_BUS  = 2'd1,   // cycle open, waiting for ack
      FETCH_NEXT = 2'd2    // idle gap, step counters
   } fetch_state_e;

   // occupancy of the local sram buffer
   typedef enum logic [1:0] {
      BUF_EMPTY   = 2'd0,  // free for the next bank
      BUF_FILLING = 2'd1,  // prefetch under way
      BUF_FULL    = 2'd2   // holding a bank until streamed out
   } buf_state_e;

endpackage
